/* list.f */
fm_cfg_pkg.sv
fm_types_pkg.sv
fm_kon_if.sv
fm_slot_seq.sv
fm_reg_decode.sv
fm_timer_a.sv
fm_kon.sv
fm_kon_top.sv
tb_fm_kon.sv

/* Bender.yml */
package:
  name: fm_kon

sources:
  - fm_cfg_pkg.sv
  - fm_types_pkg.sv
  - fm_kon_if.sv
  - fm_slot_seq.sv
  - fm_reg_decode.sv
  - fm_timer_a.sv
  - fm_kon.sv
  - fm_kon_top.sv
  - target: test
    files:
      - tb_fm_kon.sv

/* fm_kon_patterns.txt */
// Columns: kind addr data map, all hex; map bit op*6+ch is the key-on of that slot
// Kind 1 write then check map, 2 burst write, 3 setup write, 4 wait timer_flag, 5 CSM search
// Single channel on and off, then code 5
1 28 f0 041041
1 28 00 000000
1 28 f5 410410
// Partial masks, codes 3 and 7 and an unused address change nothing
1 28 31 410492
1 28 a4 610692
1 28 56 6306b2
1 28 c2 7346b2
1 28 f3 7346b2
1 28 f7 7346b2
1 30 ff 7346b2
// Back-to-back key-on writes, checked after the last one
2 28 10 000000
2 28 20 000000
2 28 91 000000
2 28 e4 000000
1 28 40 7bd632
1 28 02 6b9632
// Timer A period 1020, flag set then cleared
3 24 ff 000000
3 25 00 000000
4 27 01 000001
4 27 11 000000
// CSM forces channel 2 for one round, ring keeps channel 2 off
5 27 81 7bd736
1 27 01 6b9632

/* tb_fm_kon.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fm_kon;

    logic                  clk;
    logic                  rst;
    logic                  wr_valid;
    logic [7:0]            wr_addr;
    logic [7:0]            wr_data;
    logic                  wr_ready;
    logic                  key_on;
    fm_types_pkg::op_idx_t slot_op;
    fm_types_pkg::ch_idx_t slot_ch;
    logic                  timer_flag;

    logic [31:0] pat [0:255];         // Four words per pattern line
    int          num_pat;
    int          cycles;
    int          cycle_limit = 1000;  // Raised once the patterns are counted
    int          errors;
    int          passes;
    int          fails;

    fm_kon_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_ready   (wr_ready),
        .key_on     (key_on),
        .slot_op    (slot_op),
        .slot_ch    (slot_ch),
        .timer_flag (timer_flag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;            // 40 ns period
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles before all patterns finished", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #2;                                // Drive and sample off the edge
    endtask

    task automatic check_value(input string what, input logic [23:0] got,
                               input logic [23:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s: got %06h, expected %06h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        logic taken;
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        taken    = 1'b0;
        while (!taken) begin
            taken = wr_ready;              // Transfer on the coming edge
            step();
        end
        wr_valid = 1'b0;
    endtask

    // One round from slot (op 0, ch 0), bit op*6+ch
    task automatic record_round(output logic [23:0] map);
        int idx;
        map = '0;
        while (!(slot_op == 0 && slot_ch == 0))
            step();
        for (int n = 0; n < fm_cfg_pkg::num_slot; n++) begin
            idx = int'(slot_op) * fm_cfg_pkg::num_ch + int'(slot_ch);
            map[idx] = key_on;
            step();
        end
    endtask

    task automatic search_rounds(input logic [23:0] exp, output logic [23:0] got);
        record_round(got);
        for (int r = 1; r < 8 && got !== exp; r++)
            record_round(got);             // CSM round shows up once per overflow
    endtask

    task automatic wait_flag(input logic want);
        int n;
        n = 0;
        while (timer_flag !== want && n < 6 * fm_cfg_pkg::num_slot) begin
            step();
            n++;
        end
    endtask

    initial begin : main
        logic [3:0]  kind;
        logic [7:0]  addr;
        logic [7:0]  data;
        logic [23:0] exp;
        logic [23:0] got;
        logic        burst_prev;
        int          gap;
        int          err_before;
        int unsigned seed;

        seed     = $urandom(97);
        rst      = 1'b1;
        wr_valid = 1'b0;
        wr_addr  = 8'h00;
        wr_data  = 8'h00;
        errors   = 0;
        passes   = 0;
        fails    = 0;
        num_pat  = 0;
        $readmemh("fm_kon_patterns.txt", pat);
        while (num_pat < 64 && pat[4*num_pat] >= 32'd1 && pat[4*num_pat] <= 32'd5)
            num_pat++;                     // Unread entries stay unknown
        cycle_limit = 200 * num_pat + 1000;
        if (num_pat == 0) begin
            $display("No patterns could be read from fm_kon_patterns.txt");
            errors++;
        end

        repeat (10) step();
        rst = 1'b0;

        // Everything idle out of reset, write port opens a clock later
        err_before = errors;
        check_value("outputs after reset",
                    {16'b0, wr_ready, key_on, timer_flag, slot_op, slot_ch}, 24'h0);
        step();
        check_value("wr_ready one clock after reset", {23'b0, wr_ready}, 24'h1);
        $display("reset check: %s", errors == err_before ? "ok" : "mismatch");

        burst_prev = 1'b0;
        for (int i = 0; i < num_pat; i++) begin
            kind       = pat[4*i][3:0];
            addr       = pat[4*i+1][7:0];
            data       = pat[4*i+2][7:0];
            exp        = pat[4*i+3][23:0];
            err_before = errors;
            if (!burst_prev) begin
                gap = $urandom % 4;        // Idle gap, none inside a burst
                repeat (gap) step();
            end
            write_reg(addr, data);
            case (kind)
                4'd1: begin
                    repeat (72) step();    // Worst case key-on latency
                    record_round(got);
                    check_value($sformatf("line %0d key-on map", i), got, exp);
                end
                4'd4: begin
                    wait_flag(exp[0]);
                    check_value($sformatf("line %0d timer_flag", i), {23'b0, timer_flag}, exp);
                end
                4'd5: begin
                    search_rounds(exp, got);
                    check_value($sformatf("line %0d CSM round", i), got, exp);
                end
                default: ;                 // Burst and setup writes
            endcase
            burst_prev = kind == 4'd2;
            if (errors == err_before)
                passes++;
            else
                fails++;
            $display("test %0d kind %0d addr %02h data %02h: %s", i, kind, addr, data,
                     errors == err_before ? "ok" : "mismatch");
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors", num_pat, passes, fails,
                 errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* fm_kon_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_kon_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_valid,
    input  logic [7:0]            wr_addr,
    input  logic [7:0]            wr_data,
    output logic                  wr_ready,
    output logic                  key_on,
    output fm_types_pkg::op_idx_t slot_op,
    output fm_types_pkg::ch_idx_t slot_ch,
    output logic                  timer_flag
);

    fm_types_pkg::op_idx_t            next_op;
    fm_types_pkg::ch_idx_t            next_ch;
    logic                             round_end;
    logic [fm_cfg_pkg::timer_a_w-1:0] ta_period;
    logic                             ta_enable;
    logic                             flag_clr;
    logic                             csm;
    logic                             ovf;

    fm_kon_if kon_if ();    // Decoder to ring request

    fm_slot_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .next_op   (next_op),
        .next_ch   (next_ch),
        .round_end (round_end)
    );

    fm_reg_decode u_dec (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_ready  (wr_ready),
        .kon       (kon_if.src),
        .ta_period (ta_period),
        .ta_enable (ta_enable),
        .flag_clr  (flag_clr),
        .csm       (csm)
    );

    fm_timer_a u_timer (
        .clk        (clk),
        .rst        (rst),
        .round_end  (round_end),
        .ta_period  (ta_period),
        .ta_enable  (ta_enable),
        .flag_clr   (flag_clr),
        .ovf        (ovf),
        .timer_flag (timer_flag)
    );

    fm_kon u_kon (
        .clk     (clk),
        .rst     (rst),
        .kon     (kon_if.dst),
        .next_op (next_op),
        .next_ch (next_ch),
        .csm     (csm),
        .ovf     (ovf),
        .key_on  (key_on),
        .slot_op (slot_op),
        .slot_ch (slot_ch)
    );

endmodule

`default_nettype wire

/* fm_kon.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_kon (
    input  logic                  clk,
    input  logic                  rst,
    fm_kon_if.dst                 kon,
    input  fm_types_pkg::op_idx_t next_op,
    input  fm_types_pkg::ch_idx_t next_ch,
    input  logic                  csm,
    input  logic                  ovf,
    output logic                  key_on,
    output fm_types_pkg::op_idx_t slot_op,
    output fm_types_pkg::ch_idx_t slot_ch
);

    logic [fm_cfg_pkg::num_slot-1:0] ring_q;    // One bit per slot, circulating
    logic [fm_cfg_pkg::num_slot-1:0] ring_d;
    logic                            ring_out;  // Bit of the current slot
    logic                            pend_q;    // Request waiting for its slot
    fm_types_pkg::ch_idx_t           req_ch_q;
    fm_types_pkg::op_mask_t          req_mask_q;
    logic                            load;
    logic                            ovf_hold_q;  // CSM key-on window
    fm_types_pkg::op_idx_t           ovf_op_q;    // Slot the overflow arrived on
    fm_types_pkg::ch_idx_t           ovf_ch_q;
    logic                            csm_on;

    assign kon.ready = !pend_q;
    assign ring_out  = ring_q[fm_cfg_pkg::num_slot-1];

    // S4 slot of the requested channel
    assign load = pend_q
               && next_op == fm_types_pkg::op_idx_t'(fm_cfg_pkg::num_op - 1)
               && next_ch == req_ch_q;

    // At S4 of a channel its S3, S2, S1 bits sit 6, 12 and 18 places up the ring
    always_comb begin
        ring_d = {ring_q[fm_cfg_pkg::num_slot-2:0], ring_out};
        if (load) begin
            for (int i = 0; i < fm_cfg_pkg::num_op; i++)
                ring_d[i*fm_cfg_pkg::num_ch] = req_mask_q[fm_cfg_pkg::num_op-1-i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            ring_q <= '0;
        else
            ring_q <= ring_d;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pend_q <= 1'b0;
        else if (kon.valid && kon.ready)
            pend_q <= 1'b1;                     // Take request
        else if (load)
            pend_q <= 1'b0;                     // Written into ring
    end

    always_ff @(posedge clk) begin
        if (kon.valid && kon.ready) begin
            req_ch_q   <= kon.ch;
            req_mask_q <= kon.op_mask;
        end
    end

    // Stretch a CSM overflow over one full round
    always_ff @(posedge clk) begin
        if (rst)
            ovf_hold_q <= 1'b0;
        else if (ovf && csm)
            ovf_hold_q <= 1'b1;
        else if (next_op == ovf_op_q && next_ch == ovf_ch_q)
            ovf_hold_q <= 1'b0;                 // Back at the arrival slot
    end

    always_ff @(posedge clk) begin
        if (ovf && csm) begin
            ovf_op_q <= next_op;
            ovf_ch_q <= next_ch;
        end
    end

    assign csm_on = ovf_hold_q && next_ch == fm_types_pkg::ch_idx_t'(2);  // CSM channel

    always_ff @(posedge clk) begin
        if (rst) begin
            key_on  <= 1'b0;
            slot_op <= '0;
            slot_ch <= '0;
        end else begin
            key_on  <= ring_out || csm_on;      // Forced on, ring untouched
            slot_op <= next_op;
            slot_ch <= next_ch;
        end
    end

    // A loaded S4 bit comes round again with its own slot
    a_load_s4: assert property (@(posedge clk) disable iff (rst)
        load |-> ##(fm_cfg_pkg::num_slot)
            (next_op == $past(next_op, fm_cfg_pkg::num_slot)
             && next_ch == $past(next_ch, fm_cfg_pkg::num_slot)
             && ring_out == $past(req_mask_q[fm_cfg_pkg::num_op-1], fm_cfg_pkg::num_slot)));

endmodule

`default_nettype wire

/* fm_timer_a.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_timer_a (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             round_end,
    input  logic [fm_cfg_pkg::timer_a_w-1:0] ta_period,
    input  logic                             ta_enable,
    input  logic                             flag_clr,
    output logic                             ovf,
    output logic                             timer_flag
);

    logic [fm_cfg_pkg::timer_a_w-1:0] cnt_q;   // Counts up towards all ones

    // Overflow on the round end where the counter sits at its top
    assign ovf = ta_enable && round_end && (cnt_q == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (!ta_enable) begin
            cnt_q <= ta_period;                 // Preload while stopped
        end else if (ovf) begin
            cnt_q <= ta_period;                 // Reload
        end else if (round_end) begin
            cnt_q <= cnt_q + 1'b1;              // One step per round
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            timer_flag <= 1'b0;
        else if (ovf)
            timer_flag <= 1'b1;                 // Set beats clear
        else if (flag_clr)
            timer_flag <= 1'b0;
    end

    // At most one overflow per round
    a_ovf_round: assert property (@(posedge clk) disable iff (rst)
        ovf |=> !ovf [*(fm_cfg_pkg::num_slot-1)]);

endmodule

`default_nettype wire

/* fm_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_reg_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wr_valid,
    input  logic [7:0]                          wr_addr,
    input  logic [7:0]                          wr_data,
    output logic                                wr_ready,
    fm_kon_if.src                               kon,
    output logic [fm_cfg_pkg::timer_a_w-1:0]    ta_period,
    output logic                                ta_enable,
    output logic                                flag_clr,
    output logic                                csm
);

    logic                   up_q;       // Out of reset for a full clock
    logic                   kv_q;       // Key-on request waiting for ring
    logic                   wr_fire;
    logic [1:0]             mode_q;
    logic [2:0]             code;       // Chip channel code
    logic                   code_ok;
    fm_types_pkg::ch_idx_t  code_ch;
    fm_types_pkg::ch_idx_t  req_ch_q;
    fm_types_pkg::op_mask_t req_mask_q;

    assign wr_ready = up_q && !kv_q;              // Stall behind a waiting key-on
    assign wr_fire  = wr_valid && wr_ready;

    // Codes 0-2 are channels 0-2, codes 4-6 are channels 3-5
    assign code    = wr_data[2:0];
    assign code_ok = code[1:0] != 2'd3;           // 3 and 7 name no channel
    assign code_ch = code[2] ? {1'b0, code[1:0]} + 3'd3 : {1'b0, code[1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            up_q      <= 1'b0;
            kv_q      <= 1'b0;
            ta_period <= '0;
            ta_enable <= 1'b0;
            flag_clr  <= 1'b0;
            mode_q    <= 2'b00;
        end else begin
            up_q     <= 1'b1;
            flag_clr <= 1'b0;                     // Single clock pulse
            if (kv_q && kon.ready)
                kv_q <= 1'b0;                     // Ring took it
            if (wr_fire) begin
                case (wr_addr)
                    fm_cfg_pkg::addr_kon:   if (code_ok) kv_q <= 1'b1;
                    fm_cfg_pkg::addr_ta_hi: ta_period[fm_cfg_pkg::timer_a_w-1:2] <= wr_data;
                    fm_cfg_pkg::addr_ta_lo: ta_period[1:0] <= wr_data[1:0];
                    fm_cfg_pkg::addr_mode: begin
                        ta_enable <= wr_data[0];
                        flag_clr  <= wr_data[4];
                        mode_q    <= wr_data[7:6];
                    end
                    default: ;                    // Unused address
                endcase
            end
        end
    end

    // Request payload, only loaded while no request waits
    always_ff @(posedge clk) begin
        if (wr_fire && wr_addr == fm_cfg_pkg::addr_kon) begin
            req_ch_q   <= code_ch;
            req_mask_q <= wr_data[7:4];           // S4 down to S1
        end
    end

    assign kon.valid   = kv_q;
    assign kon.ch      = req_ch_q;
    assign kon.op_mask = req_mask_q;
    assign csm         = mode_q == fm_cfg_pkg::mode_csm;

    a_kon_stable: assert property (@(posedge clk) disable iff (rst)
        kon.valid && !kon.ready |=> kon.valid && $stable(kon.ch) && $stable(kon.op_mask));

endmodule

`default_nettype wire

/* fm_slot_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module fm_slot_seq (
    input  logic                  clk,
    input  logic                  rst,
    output fm_types_pkg::op_idx_t next_op,
    output fm_types_pkg::ch_idx_t next_ch,
    output logic                  round_end
);

    fm_types_pkg::op_idx_t op_q;    // Outer count
    fm_types_pkg::ch_idx_t ch_q;    // Inner count
    logic                  ch_last;
    logic                  op_last;

    assign ch_last = ch_q == fm_types_pkg::ch_idx_t'(fm_cfg_pkg::num_ch - 1);
    assign op_last = op_q == fm_types_pkg::op_idx_t'(fm_cfg_pkg::num_op - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q <= '0;
            ch_q <= '0;
        end else if (ch_last) begin
            ch_q <= '0;                                   // Wrap channel
            op_q <= op_last ? '0 : op_q + 1'b1;           // Next operator row
        end else begin
            ch_q <= ch_q + 1'b1;
        end
    end

    assign next_op   = op_q;
    assign next_ch   = ch_q;
    assign round_end = op_last && ch_last;    // Slot S4 of channel 5

endmodule

`default_nettype wire

/* fm_kon_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fm_kon_if;

    logic                  valid;    // Request present
    logic                  ready;    // Ring has no pending request
    fm_types_pkg::ch_idx_t ch;       // Target channel
    fm_types_pkg::op_mask_t op_mask; // New key-on bits, S1 in bit 0

    modport src (
        output valid, ch, op_mask,
        input  ready
    );

    modport dst (
        input  valid, ch, op_mask,
        output ready
    );

endinterface

`default_nettype wire

/* fm_types_pkg.sv */
`default_nettype none

package fm_types_pkg;

    // Operator index within a channel, 0 is S1
    typedef logic [$clog2(fm_cfg_pkg::num_op)-1:0] op_idx_t;

    // Channel index 0 to 5, after chip code mapping
    typedef logic [$clog2(fm_cfg_pkg::num_ch)-1:0] ch_idx_t;

    // Key-on mask of one channel
    // Bit 0 is S1, bit 3 is S4
    typedef logic [fm_cfg_pkg::num_op-1:0] op_mask_t;

endpackage

`default_nettype wire

/* fm_cfg_pkg.sv */
`default_nettype none

package fm_cfg_pkg;

    // Slot layout of one sample round
    localparam int num_ch   = 6;                  // Channels per chip
    localparam int num_op   = 4;                  // Operators per channel
    localparam int num_slot = num_ch * num_op;    // One operator slot per clock

    // Timer A
    localparam int timer_a_w = 10;                // Period and counter width

    // Host register map
    localparam logic [7:0] addr_ta_hi = 8'h24;    // Timer A bits 9:2
    localparam logic [7:0] addr_ta_lo = 8'h25;    // Timer A bits 1:0
    localparam logic [7:0] addr_mode  = 8'h27;    // Mode, timer enable, flag clear
    localparam logic [7:0] addr_kon   = 8'h28;    // Key-on, channel code and mask

    // Mode field of addr_mode, bits 7:6
    localparam logic [1:0] mode_csm = 2'b10;      // Composite sine mode

endpackage

`default_nettype wire
